/* source/trap_params.svh */
`ifndef TRAP_PARAMS_SVH
`define TRAP_PARAMS_SVH

// Entries in the committed trap uop queue
`define TRAP_QUEUE_DEPTH 4

// Fetch ID width, one PC file entry per ID
`define FETCH_ID_W 3

// Halfword offset inside a fetch packet
`define FETCH_OFF_W 3

`define XLEN 32

// medeleg and mideleg cover the standard exception and interrupt codes
`define DELEG_W 16

`endif

/* source/trapPkg.sv */
package trapPkg;

    // Exception flags from TRAP to ST_PF stay contiguous
    typedef enum logic [3:0] {
        FLAGS_NX            = 4'd0,
        FLAGS_ORDERING      = 4'd1,
        FLAGS_FENCE         = 4'd2,
        FLAGS_XRET          = 4'd3,
        FLAGS_TRAP          = 4'd4,
        FLAGS_ILLEGAL_INSTR = 4'd5,
        FLAGS_LD_MA         = 4'd6,
        FLAGS_LD_AF         = 4'd7,
        FLAGS_LD_PF         = 4'd8,
        FLAGS_ST_MA         = 4'd9,
        FLAGS_ST_AF         = 4'd10,
        FLAGS_ST_PF         = 4'd11
    } UopFlags;

    typedef enum logic [4:0] {
        TRAP_I_MA        = 5'd0,
        TRAP_I_AF        = 5'd1,
        TRAP_ILLEGAL     = 5'd2,
        TRAP_BREAK       = 5'd3,
        TRAP_LD_MA       = 5'd4,
        TRAP_LD_AF       = 5'd5,
        TRAP_ST_MA       = 5'd6,
        TRAP_ST_AF       = 5'd7,
        TRAP_ECALL_U     = 5'd8,
        TRAP_ECALL_S     = 5'd9,
        TRAP_ECALL_M     = 5'd11,
        TRAP_I_PF        = 5'd12,
        TRAP_LD_PF       = 5'd13,
        TRAP_ST_PF       = 5'd15,
        // Above the delegable range on purpose
        TRAP_CUSTOM_HANG = 5'd24
    } TrapCause;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } PrivLevel;

    // rd field of a TRAP uop, any other value is taken as the cause
    typedef enum logic [4:0] {
        TRAP_V_ECALL_M    = 5'd11,
        TRAP_V_SFENCE_VMA = 5'd16,
        TRAP_V_INTERRUPT  = 5'd17
    } TrapVector;

    typedef enum logic [1:0] {
        TGT_MANUAL = 2'd0,
        TGT_NEXT   = 2'd1,
        TGT_CUR16  = 2'd2,
        TGT_CUR32  = 2'd3
    } TargetSpec;

    typedef enum logic [2:0] {
        CSR_MTVEC   = 3'd0,
        CSR_STVEC   = 3'd1,
        CSR_MEDELEG = 3'd2,
        CSR_MIDELEG = 3'd3,
        CSR_PRIV    = 3'd4
    } CsrSel;

endpackage

/* source/trapUopQueue.sv */
`include "trap_params.svh"

module trapUopQueue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pushValid,
    input  trapPkg::UopFlags        flags,
    input  logic [4:0]              rd,
    input  logic [`FETCH_ID_W-1:0]  fetchId,
    input  logic [`FETCH_OFF_W-1:0] fetchOffs,
    input  logic                    compressed,
    input  logic                    timeout,
    output logic                    full,
    input  logic                    hold,
    output logic                    uopValid,
    output trapPkg::UopFlags        uopFlags,
    output logic [4:0]              uopRd,
    output logic [`FETCH_ID_W-1:0]  uopFetchId,
    output logic [`FETCH_OFF_W-1:0] uopFetchOffs,
    output logic                    uopCompressed,
    output logic                    uopTimeout
);

    localparam int PTR_W = $clog2(`TRAP_QUEUE_DEPTH);
    localparam int ENTRY_W = 4 + 5 + `FETCH_ID_W + `FETCH_OFF_W + 2;

    logic [ENTRY_W-1:0] entries [`TRAP_QUEUE_DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W:0] count;
    logic doPush;
    logic doPop;

    assign full = (count == (PTR_W + 1)'(`TRAP_QUEUE_DEPTH));
    assign doPush = pushValid && !full;
    // Head leaves in the same cycle it is presented
    assign doPop = (count != '0) && !hold;
    assign uopValid = doPop;

    assign {uopFlags, uopRd, uopFetchId, uopFetchOffs, uopCompressed, uopTimeout} =
        entries[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= {flags, rd, fetchId, fetchOffs, compressed, timeout};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(doPush) - (PTR_W + 1)'(doPop);
        end
    end

endmodule

/* source/pcFile.sv */
`include "trap_params.svh"

module pcFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pcWrite,
    input  logic [`FETCH_ID_W-1:0] pcWriteId,
    input  logic [`XLEN-1:0]       pcWriteData,
    input  logic [`FETCH_ID_W-1:0] readId,
    output logic [`XLEN-1:0]       packetPc
);

    localparam int ENTRIES = 1 << `FETCH_ID_W;

    logic [`XLEN-1:0] pcMem [ENTRIES];
    logic [ENTRIES-1:0] written;

    // Entries fetch has not filled since reset read as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '0;
        end else if (pcWrite) begin
            written[pcWriteId] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pcWrite) begin
            pcMem[pcWriteId] <= pcWriteData;
        end
    end

    // Registered read, a write to the same ID is forwarded
    always_ff @(posedge clk) begin
        if (pcWrite && pcWriteId == readId) begin
            packetPc <= pcWriteData;
        end else if (written[readId]) begin
            packetPc <= pcMem[readId];
        end else begin
            packetPc <= '0;
        end
    end

endmodule

/* source/trapHandler.sv */
`include "trap_params.svh"

module trapHandler (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    uopValid,
    input  trapPkg::UopFlags        flags,
    input  logic [4:0]              rd,
    input  logic [`FETCH_ID_W-1:0]  fetchId,
    input  logic [`FETCH_OFF_W-1:0] fetchOffs,
    input  logic                    compressed,
    input  logic                    timeout,
    output logic [`FETCH_ID_W-1:0]  readId,
    input  logic [`XLEN-1:0]        packetPc,
    input  trapPkg::PrivLevel       priv,
    input  logic [`XLEN-3:0]        mtvec,
    input  logic [`XLEN-3:0]        stvec,
    input  logic [`DELEG_W-1:0]     medeleg,
    input  logic [`DELEG_W-1:0]     mideleg,
    input  logic [`XLEN-2:0]        retvec,
    input  logic                    interruptPending,
    input  trapPkg::TrapCause       interruptCause,
    input  logic                    interruptDelegate,
    input  logic                    memBusy,
    output logic                    branchTaken,
    output logic [`XLEN-1:0]        branchDst,
    output logic                    branchFlush,
    output logic                    trapValid,
    output trapPkg::TrapCause       trapCause,
    output logic                    trapDelegate,
    output logic                    trapIsInterrupt,
    output logic [`XLEN-1:0]        trapPc,
    output logic                    fenceOut,
    output logic                    clearICache,
    output logic                    flushTlb,
    output logic                    hold,
    output logic [`XLEN-1:0]        dbgStallPc
);

    logic [`FETCH_OFF_W-1:0] offsR;
    trapPkg::TargetSpec specC;
    trapPkg::TargetSpec specR;
    logic [`XLEN-1:0] manualPcC;
    logic [`XLEN-1:0] manualPcR;
    logic [`XLEN-1:0] curPc;
    logic [`XLEN-1:0] dbgPcR;
    trapPkg::TrapCause excCause;
    trapPkg::TrapCause causeC;
    logic excDelegate;
    logic delegateC;
    logic isInt;
    logic isIntC;
    logic isFlushUop;
    logic isExc;
    logic trapValidC;
    logic fenceC;
    logic clearC;
    logic flushTlbC;
    logic setWait;
    logic nxC;
    logic nxR;
    logic memoryWait;

    // Packet PC arrives the cycle after the pop
    assign readId = fetchId;
    assign hold = memoryWait;
    assign curPc = {packetPc[`XLEN-1:`FETCH_OFF_W+1], offsR, 1'b0};
    assign dbgStallPc = nxR ? curPc : dbgPcR;

    always_comb begin
        case (specR)
            trapPkg::TGT_NEXT:  trapPc = curPc + `XLEN'd2;
            trapPkg::TGT_CUR16: trapPc = curPc;
            trapPkg::TGT_CUR32: trapPc = curPc - `XLEN'd2;
            default:            trapPc = manualPcR;
        endcase
    end

    always_comb begin
        isFlushUop = !timeout && (flags == trapPkg::FLAGS_FENCE ||
            flags == trapPkg::FLAGS_ORDERING || flags == trapPkg::FLAGS_XRET ||
            (flags == trapPkg::FLAGS_TRAP && rd == 5'(trapPkg::TRAP_V_SFENCE_VMA)));
        isExc = timeout || (flags >= trapPkg::FLAGS_TRAP && flags <= trapPkg::FLAGS_ST_PF);
        isInt = !timeout && flags == trapPkg::FLAGS_TRAP &&
            rd == 5'(trapPkg::TRAP_V_INTERRUPT);

        excCause = trapPkg::TRAP_ILLEGAL;
        if (timeout) begin
            excCause = trapPkg::TRAP_CUSTOM_HANG;
        end else if (isInt) begin
            excCause = interruptCause;
        end else begin
            case (flags)
                trapPkg::FLAGS_TRAP:  excCause = trapPkg::TrapCause'(rd);
                trapPkg::FLAGS_LD_MA: excCause = trapPkg::TRAP_LD_MA;
                trapPkg::FLAGS_LD_AF: excCause = trapPkg::TRAP_LD_AF;
                trapPkg::FLAGS_LD_PF: excCause = trapPkg::TRAP_LD_PF;
                trapPkg::FLAGS_ST_MA: excCause = trapPkg::TRAP_ST_MA;
                trapPkg::FLAGS_ST_AF: excCause = trapPkg::TRAP_ST_AF;
                trapPkg::FLAGS_ST_PF: excCause = trapPkg::TRAP_ST_PF;
                default: ;
            endcase
            // ecall cause follows the current privilege
            if (excCause == trapPkg::TRAP_ECALL_M) begin
                if (priv == trapPkg::PRIV_SUPERVISOR) begin
                    excCause = trapPkg::TRAP_ECALL_S;
                end else if (priv == trapPkg::PRIV_USER) begin
                    excCause = trapPkg::TRAP_ECALL_U;
                end
            end
        end
        excDelegate = excCause <= trapPkg::TRAP_ST_PF && priv != trapPkg::PRIV_MACHINE &&
            (isInt ? mideleg[excCause[3:0]] : medeleg[excCause[3:0]]);

        branchTaken = 1'b0;
        branchDst = '0;
        branchFlush = 1'b0;
        trapValidC = 1'b0;
        causeC = excCause;
        delegateC = excDelegate;
        isIntC = isInt;
        specC = trapPkg::TGT_MANUAL;
        manualPcC = '0;
        fenceC = 1'b0;
        clearC = 1'b0;
        flushTlbC = 1'b0;
        setWait = 1'b0;
        nxC = 1'b0;

        if (uopValid && isFlushUop) begin
            // branchFlush marks a resume after this instruction, branchDst unused
            branchTaken = 1'b1;
            branchFlush = 1'b1;
            case (flags)
                trapPkg::FLAGS_FENCE: begin
                    fenceC = 1'b1;
                    clearC = 1'b1;
                    setWait = 1'b1;
                end
                trapPkg::FLAGS_XRET: begin
                    branchFlush = 1'b0;
                    branchDst = {retvec, 1'b0};
                end
                trapPkg::FLAGS_TRAP: flushTlbC = 1'b1;
                default: ;
            endcase
            // Pending interrupt is taken right after xret or an ordering uop
            if ((flags == trapPkg::FLAGS_XRET || flags == trapPkg::FLAGS_ORDERING) &&
                    interruptPending) begin
                trapValidC = 1'b1;
                causeC = interruptCause;
                delegateC = interruptDelegate;
                isIntC = 1'b1;
                specC = (flags == trapPkg::FLAGS_XRET) ? trapPkg::TGT_MANUAL : trapPkg::TGT_NEXT;
                manualPcC = {retvec, 1'b0};
                branchFlush = 1'b0;
                branchDst = {interruptDelegate ? stvec : mtvec, 2'b00};
            end
        end else if (uopValid && isExc) begin
            branchTaken = 1'b1;
            branchDst = {excDelegate ? stvec : mtvec, 2'b00};
            trapValidC = 1'b1;
            specC = compressed ? trapPkg::TGT_CUR16 : trapPkg::TGT_CUR32;
        end else if (uopValid) begin
            // Leftover NX uop is only a stall PC lookup
            nxC = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trapValid <= 1'b0;
            fenceOut <= 1'b0;
            clearICache <= 1'b0;
            flushTlb <= 1'b0;
            nxR <= 1'b0;
            memoryWait <= 1'b0;
        end else begin
            trapValid <= trapValidC;
            fenceOut <= fenceC;
            clearICache <= clearC;
            flushTlb <= flushTlbC;
            nxR <= nxC;
            if (setWait) begin
                memoryWait <= 1'b1;
            end else if (!memBusy) begin
                memoryWait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        offsR <= fetchOffs;
        specR <= specC;
        manualPcR <= manualPcC;
        trapCause <= causeC;
        trapDelegate <= delegateC;
        trapIsInterrupt <= isIntC;
        dbgPcR <= dbgStallPc;
    end

endmodule

/* source/trapCsrFile.sv */
`include "trap_params.svh"

module trapCsrFile (
    input  logic                clk,
    input  logic                rst,
    input  logic                csrWrite,
    input  trapPkg::CsrSel      csrSel,
    input  logic [`XLEN-1:0]    csrData,
    input  logic                trapValid,
    input  trapPkg::TrapCause   trapCause,
    input  logic                trapDelegate,
    input  logic                trapIsInterrupt,
    input  logic [`XLEN-1:0]    trapPc,
    input  trapPkg::TrapCause   interruptCause,
    output trapPkg::PrivLevel   priv,
    output logic [`XLEN-3:0]    mtvec,
    output logic [`XLEN-3:0]    stvec,
    output logic [`DELEG_W-1:0] medeleg,
    output logic [`DELEG_W-1:0] mideleg,
    output logic [`XLEN-2:0]    retvec,
    output logic                interruptDelegate,
    output logic [`XLEN-1:0]    epcOut,
    output logic [`XLEN-1:0]    causeOut
);

    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] sepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] scause;
    logic lastSup;

    assign retvec = mepc[`XLEN-1:1];
    assign interruptDelegate = priv != trapPkg::PRIV_MACHINE && mideleg[interruptCause[3:0]];

    // Show whichever pair the last trap wrote
    assign epcOut = lastSup ? sepc : mepc;
    assign causeOut = lastSup ? scause : mcause;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= trapPkg::PRIV_MACHINE;
            mtvec <= '0;
            stvec <= '0;
            medeleg <= '0;
            mideleg <= '0;
            lastSup <= 1'b0;
        end else if (trapValid) begin
            priv <= trapDelegate ? trapPkg::PRIV_SUPERVISOR : trapPkg::PRIV_MACHINE;
            lastSup <= trapDelegate;
        end else if (csrWrite) begin
            case (csrSel)
                trapPkg::CSR_MTVEC:   mtvec <= csrData[`XLEN-1:2];
                trapPkg::CSR_STVEC:   stvec <= csrData[`XLEN-1:2];
                trapPkg::CSR_MEDELEG: medeleg <= csrData[`DELEG_W-1:0];
                trapPkg::CSR_MIDELEG: mideleg <= csrData[`DELEG_W-1:0];
                trapPkg::CSR_PRIV:    priv <= trapPkg::PrivLevel'(csrData[1:0]);
                default: ;
            endcase
        end
    end

    // Interrupt flag sits in the top bit of the cause
    always_ff @(posedge clk) begin
        if (trapValid) begin
            if (trapDelegate) begin
                sepc <= trapPc;
                scause <= {trapIsInterrupt, (`XLEN - 6)'(0), trapCause};
            end else begin
                mepc <= trapPc;
                mcause <= {trapIsInterrupt, (`XLEN - 6)'(0), trapCause};
            end
        end
    end

endmodule

/* source/trapUnit.sv */
`include "trap_params.svh"

module trapUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pushValid,
    input  trapPkg::UopFlags        flags,
    input  logic [4:0]              rd,
    input  logic [`FETCH_ID_W-1:0]  fetchId,
    input  logic [`FETCH_OFF_W-1:0] fetchOffs,
    input  logic                    compressed,
    input  logic                    timeout,
    output logic                    full,
    input  logic                    pcWrite,
    input  logic [`FETCH_ID_W-1:0]  pcWriteId,
    input  logic [`XLEN-1:0]        pcWriteData,
    input  logic                    csrWrite,
    input  trapPkg::CsrSel          csrSel,
    input  logic [`XLEN-1:0]        csrData,
    input  logic                    interruptPending,
    input  trapPkg::TrapCause       interruptCause,
    input  logic                    memBusy,
    output logic                    branchTaken,
    output logic [`XLEN-1:0]        branchDst,
    output logic                    branchFlush,
    output logic                    fenceOut,
    output logic                    clearICache,
    output logic                    flushTlb,
    output logic                    disableIFetch,
    output logic [`XLEN-1:0]        dbgStallPc,
    output trapPkg::PrivLevel       privOut,
    output logic [`XLEN-1:0]        epcOut,
    output logic [`XLEN-1:0]        causeOut
);

    logic uopValid;
    trapPkg::UopFlags uopFlags;
    logic [4:0] uopRd;
    logic [`FETCH_ID_W-1:0] uopFetchId;
    logic [`FETCH_OFF_W-1:0] uopFetchOffs;
    logic uopCompressed;
    logic uopTimeout;
    logic [`FETCH_ID_W-1:0] readId;
    logic [`XLEN-1:0] packetPc;
    logic [`XLEN-3:0] mtvec;
    logic [`XLEN-3:0] stvec;
    logic [`DELEG_W-1:0] medeleg;
    logic [`DELEG_W-1:0] mideleg;
    logic [`XLEN-2:0] retvec;
    logic interruptDelegate;
    logic trapValid;
    trapPkg::TrapCause trapCause;
    logic trapDelegate;
    logic trapIsInterrupt;
    logic [`XLEN-1:0] trapPc;

    trapUopQueue queue0 (
        .clk(clk), .rst(rst), .pushValid(pushValid), .flags(flags), .rd(rd),
        .fetchId(fetchId), .fetchOffs(fetchOffs), .compressed(compressed),
        .timeout(timeout), .full(full), .hold(disableIFetch), .uopValid(uopValid),
        .uopFlags(uopFlags), .uopRd(uopRd), .uopFetchId(uopFetchId),
        .uopFetchOffs(uopFetchOffs), .uopCompressed(uopCompressed), .uopTimeout(uopTimeout)
    );

    pcFile pcFile0 (
        .clk(clk), .rst(rst), .pcWrite(pcWrite), .pcWriteId(pcWriteId),
        .pcWriteData(pcWriteData), .readId(readId), .packetPc(packetPc)
    );

    // Fetch hold doubles as the queue stall
    trapHandler handler0 (
        .clk(clk), .rst(rst), .uopValid(uopValid), .flags(uopFlags), .rd(uopRd),
        .fetchId(uopFetchId), .fetchOffs(uopFetchOffs), .compressed(uopCompressed),
        .timeout(uopTimeout), .readId(readId), .packetPc(packetPc), .priv(privOut),
        .mtvec(mtvec), .stvec(stvec), .medeleg(medeleg), .mideleg(mideleg),
        .retvec(retvec), .interruptPending(interruptPending),
        .interruptCause(interruptCause), .interruptDelegate(interruptDelegate),
        .memBusy(memBusy), .branchTaken(branchTaken), .branchDst(branchDst),
        .branchFlush(branchFlush), .trapValid(trapValid), .trapCause(trapCause),
        .trapDelegate(trapDelegate), .trapIsInterrupt(trapIsInterrupt), .trapPc(trapPc),
        .fenceOut(fenceOut), .clearICache(clearICache), .flushTlb(flushTlb),
        .hold(disableIFetch), .dbgStallPc(dbgStallPc)
    );

    trapCsrFile csr0 (
        .clk(clk), .rst(rst), .csrWrite(csrWrite), .csrSel(csrSel), .csrData(csrData),
        .trapValid(trapValid), .trapCause(trapCause), .trapDelegate(trapDelegate),
        .trapIsInterrupt(trapIsInterrupt), .trapPc(trapPc), .interruptCause(interruptCause),
        .priv(privOut), .mtvec(mtvec), .stvec(stvec), .medeleg(medeleg), .mideleg(mideleg),
        .retvec(retvec), .interruptDelegate(interruptDelegate), .epcOut(epcOut),
        .causeOut(causeOut)
    );

endmodule

/* tests/clockGen.sv */
module clockGen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset released 1 ns after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

/* tests/trapUnitTb.sv */
`include "trap_params.svh"

module trapUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_UOPS = 22;

    logic clk;
    logic rst;
    logic pushValid;
    trapPkg::UopFlags flags;
    logic [4:0] rd;
    logic [`FETCH_ID_W-1:0] fetchId;
    logic [`FETCH_OFF_W-1:0] fetchOffs;
    logic compressed;
    logic timeout;
    logic full;
    logic pcWrite;
    logic [`FETCH_ID_W-1:0] pcWriteId;
    logic [`XLEN-1:0] pcWriteData;
    logic csrWrite;
    trapPkg::CsrSel csrSel;
    logic [`XLEN-1:0] csrData;
    logic interruptPending;
    trapPkg::TrapCause interruptCause;
    logic memBusy;
    logic branchTaken;
    logic [`XLEN-1:0] branchDst;
    logic branchFlush;
    logic fenceOut;
    logic clearICache;
    logic flushTlb;
    logic disableIFetch;
    logic [`XLEN-1:0] dbgStallPc;
    trapPkg::PrivLevel privOut;
    logic [`XLEN-1:0] epcOut;
    logic [`XLEN-1:0] causeOut;

    logic [31:0] rngState = 32'hcc01;
    int errCount = 0;
    int checkCount = 0;
    logic [`FETCH_ID_W-1:0] nextId = '0;
    logic [31:0] modelPc [$];
    logic [`FETCH_OFF_W-1:0] modelOffs [$];
    trapPkg::PrivLevel privModel;
    logic [31:0] mepcModel;
    logic [31:0] mtvecBase;
    logic [31:0] stvecBase;

    clockGen clockGen0 (.clk(clk), .rst(rst));

    trapUnit dut0 (
        .clk(clk), .rst(rst), .pushValid(pushValid), .flags(flags), .rd(rd),
        .fetchId(fetchId), .fetchOffs(fetchOffs), .compressed(compressed),
        .timeout(timeout), .full(full), .pcWrite(pcWrite), .pcWriteId(pcWriteId),
        .pcWriteData(pcWriteData), .csrWrite(csrWrite), .csrSel(csrSel),
        .csrData(csrData), .interruptPending(interruptPending),
        .interruptCause(interruptCause), .memBusy(memBusy), .branchTaken(branchTaken),
        .branchDst(branchDst), .branchFlush(branchFlush), .fenceOut(fenceOut),
        .clearICache(clearICache), .flushTlb(flushTlb), .disableIFetch(disableIFetch),
        .dbgStallPc(dbgStallPc), .privOut(privOut), .epcOut(epcOut), .causeOut(causeOut)
    );

    function logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // RISC-V cause codes for each flag, ecall cause by privilege
    function automatic logic [4:0] expectedCause(input trapPkg::UopFlags f,
            input logic [4:0] r, input logic tmo, input trapPkg::PrivLevel p);
        if (tmo) begin
            return 5'd24;
        end
        case (f)
            trapPkg::FLAGS_TRAP: begin
                if (r != 5'd11) begin
                    return r;
                end
                return (p == trapPkg::PRIV_USER) ? 5'd8 :
                    (p == trapPkg::PRIV_SUPERVISOR) ? 5'd9 : 5'd11;
            end
            trapPkg::FLAGS_LD_MA: return 5'd4;
            trapPkg::FLAGS_LD_AF: return 5'd5;
            trapPkg::FLAGS_LD_PF: return 5'd13;
            trapPkg::FLAGS_ST_MA: return 5'd6;
            trapPkg::FLAGS_ST_AF: return 5'd7;
            trapPkg::FLAGS_ST_PF: return 5'd15;
            default: return 5'd2;
        endcase
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic writeCsr(input trapPkg::CsrSel sel, input logic [31:0] data);
        @(posedge clk);
        #1;
        csrWrite = 1'b1;
        csrSel = sel;
        csrData = data;
        @(posedge clk);
        #1;
        csrWrite = 1'b0;
    endtask

    // Fetch writes the packet PC in the same cycle commit pushes the uop
    task automatic pushUop(input trapPkg::UopFlags f, input logic [4:0] r,
            input logic comp, input logic tmo);
        logic [31:0] pc;
        logic [31:0] rnd;
        pc = nextRand() & 32'hffff_fff0;
        rnd = nextRand();
        @(posedge clk);
        #1;
        pcWrite = 1'b1;
        pcWriteId = nextId;
        pcWriteData = pc;
        pushValid = 1'b1;
        flags = f;
        rd = r;
        fetchId = nextId;
        fetchOffs = rnd[18:16];
        compressed = comp;
        timeout = tmo;
        modelPc.push_back(pc);
        modelOffs.push_back(rnd[18:16]);
        nextId = nextId + 1'b1;
        @(posedge clk);
        #1;
        pushValid = 1'b0;
        pcWrite = 1'b0;
        @(negedge clk);
    endtask

    task automatic waitPop(output logic [31:0] pc, output logic [`FETCH_OFF_W-1:0] offs);
        while (dut0.uopValid !== 1'b1) begin
            @(negedge clk);
        end
        pc = modelPc.pop_front();
        offs = modelOffs.pop_front();
    endtask

    task automatic trapCheck(input trapPkg::UopFlags f, input logic [4:0] r,
            input logic comp, input logic tmo, input logic deleg);
        logic [31:0] pc;
        logic [`FETCH_OFF_W-1:0] offs;
        logic [31:0] cause;
        logic [31:0] epc;
        trapPkg::PrivLevel newPriv;
        cause = {27'b0, expectedCause(f, r, tmo, privModel)};
        newPriv = deleg ? trapPkg::PRIV_SUPERVISOR : trapPkg::PRIV_MACHINE;
        pushUop(f, r, comp, tmo);
        waitPop(pc, offs);
        checkVal("branchTaken", 32'(branchTaken), 32'd1);
        checkVal("branchDst", branchDst, deleg ? stvecBase : mtvecBase);
        epc = pc + {28'b0, offs, 1'b0} - (comp ? 32'd0 : 32'd2);
        @(negedge clk);
        @(negedge clk);
        checkVal("epcOut", epcOut, epc);
        checkVal("causeOut", causeOut, cause);
        checkVal("privOut", 32'(privOut), 32'(newPriv));
        privModel = newPriv;
        if (!deleg) begin
            mepcModel = epc;
        end
    endtask

    task automatic nxCheck();
        logic [31:0] pc;
        logic [`FETCH_OFF_W-1:0] offs;
        waitPop(pc, offs);
        checkVal("branchTaken", 32'(branchTaken), 32'd0);
        @(negedge clk);
        checkVal("dbgStallPc", dbgStallPc, pc + {28'b0, offs, 1'b0});
    endtask

    task automatic flushCheck(input trapPkg::UopFlags f, input logic [4:0] r);
        logic [31:0] pc;
        logic [`FETCH_OFF_W-1:0] offs;
        logic [31:0] oldCause;
        logic [31:0] oldEpc;
        oldCause = causeOut;
        oldEpc = epcOut;
        pushUop(f, r, 1'b0, 1'b0);
        waitPop(pc, offs);
        checkVal("branchTaken", 32'(branchTaken), 32'd1);
        if (f == trapPkg::FLAGS_XRET) begin
            checkVal("branchDst", branchDst, mepcModel & 32'hffff_fffe);
        end else begin
            checkVal("branchFlush", 32'(branchFlush), 32'd1);
        end
        @(negedge clk);
        checkVal("flushTlb", 32'(flushTlb), (f == trapPkg::FLAGS_TRAP) ? 32'd1 : 32'd0);
        @(negedge clk);
        checkVal("causeOut", causeOut, oldCause);
        checkVal("epcOut", epcOut, oldEpc);
    endtask

    task automatic xretIrqCheck();
        logic [31:0] pc;
        logic [`FETCH_OFF_W-1:0] offs;
        @(posedge clk);
        #1;
        interruptPending = 1'b1;
        interruptCause = trapPkg::TRAP_ST_AF;
        pushUop(trapPkg::FLAGS_XRET, 5'd0, 1'b0, 1'b0);
        waitPop(pc, offs);
        checkVal("branchTaken", 32'(branchTaken), 32'd1);
        checkVal("branchDst", branchDst, mtvecBase);
        @(negedge clk);
        @(negedge clk);
        checkVal("epcOut", epcOut, mepcModel);
        checkVal("causeOut", causeOut, 32'h8000_0007);
        checkVal("privOut", 32'(privOut), 32'(trapPkg::PRIV_MACHINE));
        @(posedge clk);
        #1;
        interruptPending = 1'b0;
    endtask

    task automatic fenceCheck();
        logic [31:0] pc;
        logic [`FETCH_OFF_W-1:0] offs;
        @(posedge clk);
        #1;
        memBusy = 1'b1;
        pushUop(trapPkg::FLAGS_FENCE, 5'd0, 1'b0, 1'b0);
        waitPop(pc, offs);
        checkVal("branchTaken", 32'(branchTaken), 32'd1);
        @(negedge clk);
        checkVal("fenceOut", 32'(fenceOut), 32'd1);
        checkVal("clearICache", 32'(clearICache), 32'd1);
        checkVal("disableIFetch", 32'(disableIFetch), 32'd1);
        // Held queue fills up behind the fence
        for (int k = 0; k < `TRAP_QUEUE_DEPTH; k++) begin
            pushUop(trapPkg::FLAGS_NX, 5'd0, 1'b0, 1'b0);
        end
        checkVal("full", 32'(full), 32'd1);
        checkVal("uopValid", 32'(dut0.uopValid), 32'd0);
        checkVal("disableIFetch", 32'(disableIFetch), 32'd1);
        checkVal("fenceOut", 32'(fenceOut), 32'd0);
        checkVal("clearICache", 32'(clearICache), 32'd0);
        @(posedge clk);
        #1 memBusy = 1'b0;
        @(negedge clk);
        for (int k = 0; k < `TRAP_QUEUE_DEPTH; k++) begin
            nxCheck();
        end
        checkVal("disableIFetch", 32'(disableIFetch), 32'd0);
    endtask

    initial begin
        repeat (NUM_UOPS * 20) @(posedge clk);
        $display("Watchdog timeout, the run did not finish");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        pushValid = 1'b0;
        flags = trapPkg::FLAGS_NX;
        rd = '0;
        fetchId = '0;
        fetchOffs = '0;
        compressed = 1'b0;
        timeout = 1'b0;
        pcWrite = 1'b0;
        pcWriteId = '0;
        pcWriteData = '0;
        csrWrite = 1'b0;
        csrSel = trapPkg::CSR_MTVEC;
        csrData = '0;
        interruptPending = 1'b0;
        interruptCause = trapPkg::TRAP_I_MA;
        memBusy = 1'b0;
        privModel = trapPkg::PRIV_MACHINE;
        mepcModel = '0;
        mtvecBase = nextRand() & 32'hffff_fffc;
        stvecBase = nextRand() & 32'hffff_fffc;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        checkVal("privOut", 32'(privOut), 32'(trapPkg::PRIV_MACHINE));
        checkVal("disableIFetch", 32'(disableIFetch), 32'd0);
        checkVal("branchTaken", 32'(branchTaken), 32'd0);
        checkVal("fenceOut", 32'(fenceOut), 32'd0);
        checkVal("clearICache", 32'(clearICache), 32'd0);
        checkVal("flushTlb", 32'(flushTlb), 32'd0);
        checkVal("uopValid", 32'(dut0.uopValid), 32'd0);
        writeCsr(trapPkg::CSR_MTVEC, mtvecBase);
        writeCsr(trapPkg::CSR_STVEC, stvecBase);

        for (int i = 5; i <= 11; i++) begin
            trapCheck(trapPkg::UopFlags'(i[3:0]), 5'd0, i[0], 1'b0, 1'b0);
        end
        trapCheck(trapPkg::FLAGS_TRAP, 5'd3, 1'b1, 1'b0, 1'b0);
        trapCheck(trapPkg::FLAGS_TRAP, 5'd11, 1'b0, 1'b0, 1'b0);
        trapCheck(trapPkg::FLAGS_NX, 5'd0, 1'b1, 1'b1, 1'b0);

        // ecall from user mode delegated through medeleg bit 8
        writeCsr(trapPkg::CSR_MEDELEG, 32'h0000_0100);
        writeCsr(trapPkg::CSR_PRIV, 32'd0);
        privModel = trapPkg::PRIV_USER;
        trapCheck(trapPkg::FLAGS_TRAP, 5'd11, 1'b0, 1'b0, 1'b1);
        trapCheck(trapPkg::FLAGS_LD_AF, 5'd0, 1'b1, 1'b0, 1'b0);

        flushCheck(trapPkg::FLAGS_ORDERING, 5'd0);
        flushCheck(trapPkg::FLAGS_TRAP, 5'd16);
        flushCheck(trapPkg::FLAGS_XRET, 5'd0);
        xretIrqCheck();
        pushUop(trapPkg::FLAGS_NX, 5'd0, 1'b0, 1'b0);
        nxCheck();
        fenceCheck();

        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+source
source/trapPkg.sv
source/trapUopQueue.sv
source/pcFile.sv
source/trapHandler.sv
source/trapCsrFile.sv
source/trapUnit.sv
tests/clockGen.sv
tests/trapUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := trapUnitTb
FLIST     := flist.f
BUILD     := obj_dir
LOG       := sim.log

SIM     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) source/trap_params.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^Done: no errors$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
